// ==== list.f ====
+incdir+hw
hw/apb_iob_pkg.sv
hw/apb2iob.sv
hw/iob_addr_decoder.sv
hw/iob_reg_bank.sv
hw/iob_rsp_merge.sv
hw/apb_iob_subsys.sv
tests/apb_iob_subsys_tb.sv

// ==== tests/apb_iob_subsys_tb.sv ====
`timescale 1ns/10ps
`include "apb_iob_settings.svh"

module apb_iob_subsys_tb;

   localparam int NB        = `APB_IOB_N_BANKS;
   localparam int NR        = `APB_IOB_N_REGS;
   localparam int N_TRANS   = 161; // Transfers over all tests
   localparam int RST_CYC   = 10;
   localparam int LIMIT_CYC = N_TRANS * 10 + RST_CYC;

   logic                       clk = 1'b0;
   logic                       arst_n;
   logic                       apb_sel;
   logic                       apb_enable;
   logic                       apb_write_en;
   logic [`APB_IOB_ADDR_W-1:0] apb_addr;
   logic [`APB_IOB_DATA_W-1:0] apb_wdata;
   logic [`APB_IOB_STRB_W-1:0] apb_wstrb;
   logic                       apb_ready;
   logic [`APB_IOB_DATA_W-1:0] apb_rdata;
   logic                       apb_slverr;

   logic [31:0] model [NB][NR-1]; // Mirror of the read/write words
   logic [31:0] lfsr_q = 32'h5b5b66f7;
   string       cur_test = "";
   int          test_errs = 0;
   int          n_pass = 0;
   int          n_fail = 0;
   logic        slverr_seen;
   logic        slverr_early; // Slave error sampled while ready still low

   apb_iob_subsys apb_iob_subsys_i (
      .clk_i        (clk),
      .arst_n_i     (arst_n),
      .apb_sel_i    (apb_sel),
      .apb_enable_i (apb_enable),
      .apb_write_i  (apb_write_en),
      .apb_addr_i   (apb_addr),
      .apb_wdata_i  (apb_wdata),
      .apb_wstrb_i  (apb_wstrb),
      .apb_ready_o  (apb_ready),
      .apb_rdata_o  (apb_rdata),
      .apb_slverr_o (apb_slverr)
   );

   always #10 clk = ~clk;

   // Fibonacci LFSR with taps 32 22 2 1 and one shift per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
         v      = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   function automatic logic [31:0] reg_addr(input int bank, input int r);
      return 32'((bank << 4) | (r << 2)); // Bank in bits 5:4, register in 3:2
   endfunction

   function automatic logic [31:0] id_word(input int bank);
      return {8'hA5, 16'h0000, 8'(bank)};
   endfunction

   function automatic logic [31:0] expected_word(input int bank, input int r);
      if (r == NR - 1)
         return id_word(bank);
      return model[bank][r];
   endfunction

   task automatic model_write(input int bank, input int r, input logic [31:0] d,
                              input logic [3:0] s);
      if (r == NR - 1)
         return; // ID word is read-only
      for (int b = 0; b < 4; b++) begin
         if (s[b])
            model[bank][r][8*b +: 8] = d[8*b +: 8];
      end
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      test_errs = 0;
   endtask

   task automatic finish_test();
      if (test_errs == 0) begin
         n_pass++;
         $display("%s: PASS", cur_test);
      end else begin
         n_fail++;
         $display("%s: FAIL, %0d errors", cur_test, test_errs);
      end
   endtask

   // Select cycle, then enable cycle, then hold until ready
   task automatic run_transfer(input logic wr, input logic [31:0] addr, input logic [31:0] d,
                               input logic [3:0] s, input logic en, output logic [31:0] rdata);
      int n;
      @(posedge clk);
      apb_sel      <= 1'b1;
      apb_enable   <= 1'b0;
      apb_write_en <= wr;
      apb_addr     <= addr;
      apb_wdata    <= d;
      apb_wstrb    <= s;
      @(posedge clk);
      apb_enable   <= en;
      n            = 0;
      slverr_seen  = 1'b0;
      slverr_early = 1'b0;
      @(negedge clk);
      while (!apb_ready && n < 20) begin
         if (apb_slverr) begin
            slverr_seen  = 1'b1;
            slverr_early = 1'b1;
         end
         n++;
         @(negedge clk);
      end
      if (apb_slverr)
         slverr_seen = 1'b1;
      rdata = apb_rdata; // Valid together with ready
      if (!apb_ready) begin
         $display("%s: no ready from the DUT for address %h", cur_test, addr);
         test_errs++;
      end
      if (en && slverr_seen) begin
         $display("%s: unexpected slave error for address %h", cur_test, addr);
         test_errs++;
      end
      @(posedge clk);
      apb_sel    <= 1'b0;
      apb_enable <= 1'b0;
   endtask

   task automatic apb_write(input logic [31:0] addr, input logic [31:0] d, input logic [3:0] s);
      logic [31:0] unused;
      run_transfer(1'b1, addr, d, s, 1'b1, unused);
   endtask

   task automatic apb_read(input logic [31:0] addr, output logic [31:0] d);
      run_transfer(1'b0, addr, '0, '0, 1'b1, d);
   endtask

   task automatic check_read(input logic [31:0] addr, input logic [31:0] exp);
      logic [31:0] act;
      apb_read(addr, act);
      if (act !== exp) begin
         $display("[ERROR] %s: address %h expected %h actual %h", cur_test, addr, exp, act);
         test_errs++;
      end
   endtask

   task automatic rw_registers();
      logic [31:0] d;
      start_test("rw_registers");
      for (int b = 0; b < NB; b++) begin
         for (int r = 0; r < NR - 1; r++) begin
            d = {8'(b), 8'(r), 16'hC0DE}; // Distinct per word
            apb_write(reg_addr(b, r), d, 4'hF);
            model_write(b, r, d, 4'hF);
         end
      end
      for (int b = 0; b < NB; b++) begin
         for (int r = 0; r < NR - 1; r++)
            check_read(reg_addr(b, r), expected_word(b, r));
      end
      finish_test();
   endtask

   task automatic byte_strobes();
      logic [31:0] d;
      int          r;
      start_test("byte_strobes");
      for (int b = 0; b < NB; b++) begin
         r = b % (NR - 1);
         apb_write(reg_addr(b, r), 32'hFFFF_FFFF, 4'hF);
         model_write(b, r, 32'hFFFF_FFFF, 4'hF);
         for (int k = 0; k < 4; k++) begin
            d = rand_bits(32);
            apb_write(reg_addr(b, r), d, 4'(1 << k));
            model_write(b, r, d, 4'(1 << k));
            check_read(reg_addr(b, r), expected_word(b, r));
         end
      end
      finish_test();
   endtask

   task automatic id_words();
      start_test("id_words");
      for (int b = 0; b < NB; b++) begin
         check_read(reg_addr(b, NR - 1), id_word(b));
         apb_write(reg_addr(b, NR - 1), rand_bits(32), 4'hF);
         check_read(reg_addr(b, NR - 1), id_word(b));
      end
      finish_test();
   endtask

   task automatic unmapped_access();
      logic [31:0] addrs [2];
      start_test("unmapped_access");
      addrs[0] = 32'h8000_0014; // Bank 1 word 1 with the top bit set
      addrs[1] = 32'h0000_0064; // Bank 2 word 1 with bit 6 set
      foreach (addrs[i]) begin
         apb_write(addrs[i], 32'hDEAD_BEEF, 4'hF);
         check_read(addrs[i], 32'h0);
         check_read(addrs[i] & 32'h3F, expected_word(addrs[i][5:4], addrs[i][3:2]));
      end
      finish_test();
   endtask

   task automatic protocol_error();
      logic [31:0] d;
      start_test("protocol_error");
      run_transfer(1'b0, reg_addr(0, 0), '0, '0, 1'b0, d); // Enable never raised
      if (!slverr_early) begin
         $display("%s: slave error did not rise before ready", cur_test);
         test_errs++;
      end
      apb_write(reg_addr(2, 1), 32'h1234_5678, 4'hF);
      model_write(2, 1, 32'h1234_5678, 4'hF);
      check_read(reg_addr(2, 1), expected_word(2, 1));
      finish_test();
   endtask

   task automatic random_traffic();
      logic        op;
      int          b;
      int          r;
      logic [31:0] d;
      logic [3:0]  s;
      start_test("random_traffic");
      for (int i = 0; i < 64; i++) begin
         op = 1'(rand_bits(1));
         b  = rand_bits(2);
         r  = rand_bits(2);
         if (op) begin
            d = rand_bits(32);
            s = 4'(rand_bits(4));
            if (s == 4'h0)
               s = 4'hF; // A zero strobe would turn into a read
            apb_write(reg_addr(b, r), d, s);
            model_write(b, r, d, s);
         end else begin
            check_read(reg_addr(b, r), expected_word(b, r));
         end
      end
      for (int bb = 0; bb < NB; bb++) begin
         for (int rr = 0; rr < NR; rr++)
            check_read(reg_addr(bb, rr), expected_word(bb, rr)); // Final sweep
      end
      finish_test();
   endtask

   initial begin
      arst_n       <= 1'b0;
      apb_sel      <= 1'b0;
      apb_enable   <= 1'b0;
      apb_write_en <= 1'b0;
      apb_addr     <= '0;
      apb_wdata    <= '0;
      apb_wstrb    <= '0;
      for (int b = 0; b < NB; b++) begin
         for (int r = 0; r < NR - 1; r++)
            model[b][r] = '0;
      end
      repeat (RST_CYC) @(posedge clk);
      arst_n <= 1'b1;
      repeat (2) @(posedge clk);
      rw_registers();
      byte_strobes();
      id_words();
      unmapped_access();
      protocol_error();
      random_traffic();
      $display("Summary: %0d passed, %0d failed", n_pass, n_fail);
      if (n_fail == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

   // Watchdog
   initial begin
      repeat (LIMIT_CYC) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d cycles", LIMIT_CYC);
      $display("test failed");
      $finish;
   end

endmodule

// ==== hw/apb_iob_subsys.sv ====
`timescale 1ns/10ps
`include "apb_iob_settings.svh"

module apb_iob_subsys import apb_iob_pkg::*; (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  logic                       apb_sel_i,
   input  logic                       apb_enable_i,
   input  logic                       apb_write_i,
   input  logic [`APB_IOB_ADDR_W-1:0] apb_addr_i,
   input  logic [`APB_IOB_DATA_W-1:0] apb_wdata_i,
   input  logic [`APB_IOB_STRB_W-1:0] apb_wstrb_i,
   output logic                       apb_ready_o,
   output logic [`APB_IOB_DATA_W-1:0] apb_rdata_o,
   output logic                       apb_slverr_o
);

   iob_req_t  iob_req;
   iob_rsp_t  iob_rsp;
   iob_req_t  bank_req [`APB_IOB_N_BANKS];
   iob_rsp_t  bank_rsp [`APB_IOB_N_BANKS];
   bank_idx_t bank_idx;
   logic      unmapped;

   apb2iob apb2iob_i (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .apb_sel_i    (apb_sel_i),
      .apb_enable_i (apb_enable_i),
      .apb_write_i  (apb_write_i),
      .apb_addr_i   (apb_addr_i),
      .apb_wdata_i  (apb_wdata_i),
      .apb_wstrb_i  (apb_wstrb_i),
      .apb_ready_o  (apb_ready_o),
      .apb_rdata_o  (apb_rdata_o),
      .apb_slverr_o (apb_slverr_o),
      .iob_req_o    (iob_req),
      .iob_rsp_i    (iob_rsp)
   );

   iob_addr_decoder iob_addr_decoder_i (
      .req_i      (iob_req),
      .bank_req_o (bank_req),
      .bank_idx_o (bank_idx),
      .unmapped_o (unmapped)
   );

   for (genvar g = 0; g < `APB_IOB_N_BANKS; g++) begin : g_bank
      iob_reg_bank #(
         .BANK_ID (g)
      ) iob_reg_bank_i (
         .clk_i    (clk_i),
         .arst_n_i (arst_n_i),
         .req_i    (bank_req[g]),
         .rsp_o    (bank_rsp[g])
      );
   end

   iob_rsp_merge iob_rsp_merge_i (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .bank_rsp_i (bank_rsp),
      .bank_idx_i (bank_idx),
      .unmapped_i (unmapped),
      .req_i      (iob_req),
      .rsp_o      (iob_rsp)
   );

endmodule

// ==== hw/iob_rsp_merge.sv ====
`timescale 1ns/10ps
`include "apb_iob_settings.svh"

module iob_rsp_merge import apb_iob_pkg::*; (
   input  logic      clk_i,
   input  logic      arst_n_i,
   input  iob_rsp_t  bank_rsp_i [`APB_IOB_N_BANKS],
   input  bank_idx_t bank_idx_i,
   input  logic      unmapped_i,
   input  iob_req_t  req_i,
   output iob_rsp_t  rsp_o
);

   bank_idx_t bank_q;      // Bank that took the last read
   logic      unm_q;       // Last read went to the unmapped path
   logic      unm_rvalid_q;
   logic      ready;
   logic      rd_acc;

   // Unmapped path answers at once
   assign ready  = unmapped_i ? req_i.avalid : bank_rsp_i[bank_idx_i].ready;
   assign rd_acc = req_i.avalid && ready && (req_i.wstrb == '0);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         bank_q       <= '0;
         unm_q        <= 1'b0;
         unm_rvalid_q <= 1'b0;
      end else begin
         unm_rvalid_q <= rd_acc && unmapped_i;
         if (rd_acc) begin
            bank_q <= bank_idx_i;
            unm_q  <= unmapped_i;
         end
      end
   end

   always_comb begin
      rsp_o.ready = ready;
      if (unm_q) begin
         rsp_o.rvalid = unm_rvalid_q;
         rsp_o.rdata  = '0;        // Unmapped reads return zero
      end else begin
         rsp_o.rvalid = bank_rsp_i[bank_q].rvalid;
         rsp_o.rdata  = bank_rsp_i[bank_q].rdata;
      end
   end

endmodule

// ==== hw/iob_reg_bank.sv ====
`timescale 1ns/10ps
`include "apb_iob_settings.svh"

module iob_reg_bank import apb_iob_pkg::*; #(
   parameter int BANK_ID = 0
) (
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  iob_req_t req_i,
   output iob_rsp_t rsp_o
);

   localparam int REG_W  = $clog2(`APB_IOB_N_REGS);
   localparam int N_RW   = `APB_IOB_N_REGS - 1;
   localparam int ID_IDX = `APB_IOB_N_REGS - 1;
   localparam logic [`APB_IOB_DATA_W-1:0] ID_WORD =
      {`APB_IOB_ID_MARK, {(`APB_IOB_DATA_W-16){1'b0}}, 8'(BANK_ID)};

   logic [`APB_IOB_DATA_W-1:0] regs [N_RW];
   logic [REG_W-1:0]           reg_idx;
   logic                       ready_q;
   logic                       rvalid_q;
   logic [`APB_IOB_DATA_W-1:0] rdata_q;
   logic                       acc;
   logic                       wr_en;
   logic                       rd_en;

   assign reg_idx = req_i.addr[`APB_IOB_REG_LSB +: REG_W];
   assign acc     = req_i.avalid && ready_q;
   assign wr_en   = acc && (|req_i.wstrb) && (reg_idx != REG_W'(ID_IDX));
   assign rd_en   = acc && (req_i.wstrb == '0);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ready_q  <= 1'b0;
         rvalid_q <= 1'b0;
         for (int r = 0; r < N_RW; r++)
            regs[r] <= '0;
      end else begin
         ready_q  <= 1'b1; // Always ready once out of reset
         rvalid_q <= rd_en;
         for (int r = 0; r < N_RW; r++) begin
            for (int b = 0; b < `APB_IOB_STRB_W; b++) begin
               if (wr_en && (reg_idx == REG_W'(r)) && req_i.wstrb[b])
                  regs[r][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
         end
      end
   end

   // Read word held until the next read
   always_ff @(posedge clk_i) begin
      if (rd_en)
         rdata_q <= (reg_idx == REG_W'(ID_IDX)) ? ID_WORD : regs[reg_idx];
   end

   assign rsp_o.ready  = ready_q;
   assign rsp_o.rvalid = rvalid_q;
   assign rsp_o.rdata  = rdata_q;

endmodule

// ==== hw/iob_addr_decoder.sv ====
`timescale 1ns/10ps
`include "apb_iob_settings.svh"

module iob_addr_decoder import apb_iob_pkg::*; (
   input  iob_req_t  req_i,
   output iob_req_t  bank_req_o [`APB_IOB_N_BANKS],
   output bank_idx_t bank_idx_o,
   output logic      unmapped_o
);

   localparam int REG_W    = $clog2(`APB_IOB_N_REGS);
   localparam int BANK_W   = $clog2(`APB_IOB_N_BANKS);
   localparam int BANK_LSB = `APB_IOB_REG_LSB + REG_W;
   localparam int HIGH_LSB = BANK_LSB + BANK_W; // First bit outside the map

   logic high_hit;

   // Any set bit above the bank field leaves the map
   assign high_hit   = |req_i.addr[`APB_IOB_ADDR_W-1:HIGH_LSB];
   assign bank_idx_o = req_i.addr[BANK_LSB +: BANK_W];
   assign unmapped_o = req_i.avalid && high_hit;

   always_comb begin
      for (int i = 0; i < `APB_IOB_N_BANKS; i++) begin
         bank_req_o[i]        = req_i;
         bank_req_o[i].avalid = req_i.avalid && !high_hit &&
                                (bank_idx_o == bank_idx_t'(i));
      end
   end

endmodule

// ==== hw/apb2iob.sv ====
`timescale 1ns/10ps
`include "apb_iob_settings.svh"

module apb2iob import apb_iob_pkg::*; (
   input  logic                       clk_i,
   input  logic                       arst_n_i,

   // APB slave
   input  logic                       apb_sel_i,
   input  logic                       apb_enable_i,
   input  logic                       apb_write_i,
   input  logic [`APB_IOB_ADDR_W-1:0] apb_addr_i,
   input  logic [`APB_IOB_DATA_W-1:0] apb_wdata_i,
   input  logic [`APB_IOB_STRB_W-1:0] apb_wstrb_i,
   output logic                       apb_ready_o,
   output logic [`APB_IOB_DATA_W-1:0] apb_rdata_o,
   output logic                       apb_slverr_o,

   // IOb master
   output iob_req_t                   iob_req_o,
   input  iob_rsp_t                   iob_rsp_i
);

   bridge_state_e state_q, state_d;
   logic          avalid_q, avalid_d;
   logic          ready_d;
   logic          slverr_d;
   logic          accepted;

   assign accepted = (state_q == BR_ACCESS) && avalid_q && iob_rsp_i.ready;

   always_comb begin
      state_d  = state_q;
      avalid_d = avalid_q;
      slverr_d = 1'b0;

      case (state_q)
         BR_IDLE: begin
            if (apb_sel_i) begin
               avalid_d = 1'b1;
               state_d  = BR_ACCESS;
            end
         end
         BR_ACCESS: begin
            if (!apb_enable_i)
               slverr_d = 1'b1; // Access phase without enable
            if (iob_rsp_i.ready) begin
               avalid_d = 1'b0;
               state_d  = BR_WAIT_END;
            end
         end
         BR_WAIT_END: begin
            if (!apb_sel_i)
               state_d = BR_IDLE;
         end
         default: begin
            avalid_d = 1'b0;
            state_d  = BR_IDLE;
         end
      endcase
   end

   // Write ends on acceptance, read ends on the returned data
   assign ready_d = apb_write_i ? accepted : iob_rsp_i.rvalid;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q      <= BR_IDLE;
         avalid_q     <= 1'b0;
         apb_ready_o  <= 1'b0;
         apb_slverr_o <= 1'b0;
      end else begin
         state_q      <= state_d;
         avalid_q     <= avalid_d;
         apb_ready_o  <= ready_d;
         apb_slverr_o <= slverr_d;
      end
   end

   // Read data is caught with rvalid so it lines up with ready
   always_ff @(posedge clk_i) begin
      if (iob_rsp_i.rvalid)
         apb_rdata_o <= iob_rsp_i.rdata;
   end

   always_comb begin
      iob_req_o.avalid = avalid_q;
      iob_req_o.addr   = apb_addr_i;
      iob_req_o.wdata  = apb_wdata_i;
      iob_req_o.wstrb  = apb_write_i ? apb_wstrb_i : '0; // No strobes on a read
   end

endmodule

// ==== hw/apb_iob_pkg.sv ====
`include "apb_iob_settings.svh"

package apb_iob_pkg;

   // IOb request, master to slave
   typedef struct packed {
      logic                       avalid;
      logic [`APB_IOB_ADDR_W-1:0] addr;
      logic [`APB_IOB_DATA_W-1:0] wdata;
      logic [`APB_IOB_STRB_W-1:0] wstrb; // All zero means read
   } iob_req_t;

   // IOb response, slave to master
   typedef struct packed {
      logic                       ready;
      logic                       rvalid;
      logic [`APB_IOB_DATA_W-1:0] rdata;
   } iob_rsp_t;

   // Bridge sequencer
   typedef enum logic [1:0] {
      BR_IDLE     = 2'd0, // Wait for select
      BR_ACCESS   = 2'd1, // Request out on IOb
      BR_WAIT_END = 2'd2  // Wait for select to drop
   } bridge_state_e;

   typedef logic [$clog2(`APB_IOB_N_BANKS)-1:0] bank_idx_t;

endpackage

// ==== hw/apb_iob_settings.svh ====
`ifndef APB_IOB_SETTINGS_SVH
`define APB_IOB_SETTINGS_SVH

// Bus widths shared by the APB side and the IOb side
`define APB_IOB_ADDR_W 32
`define APB_IOB_DATA_W 32
`define APB_IOB_STRB_W (`APB_IOB_DATA_W / 8)

// Register map size
`define APB_IOB_N_BANKS 4 // Power of two
`define APB_IOB_N_REGS  4 // Last word of each bank is the ID word

// Identification word marker in the top byte
`define APB_IOB_ID_MARK 8'hA5

// Word offset inside a byte address
`define APB_IOB_REG_LSB 2

`endif
